//--- flist.f
rob_pkg.sv
rob_entry.sv
rob_ptr_counter.sv
rob_retire_ctrl.sv
rob_top.sv
rob_tb.sv

//--- rob_tb.sv
`timescale 1ns/1ns

module rob_tb;

   import rob_pkg::*;

   localparam int DEPTH = 8;
   localparam int PC_W = 32;
   localparam int ID_W = $clog2(DEPTH);
   // Well above the cycles the five tests need
   localparam int MAX_CYCLES = 2000;

   logic              clk = 1'b0;
   logic              reset;
   logic              alloc;
   logic [DEST_W-1:0] alloc_dest;
   logic [PC_W-1:0]   alloc_pc;
   logic              wb_valid;
   logic [ID_W-1:0]   wb_id;
   logic              wb_mispred;
   logic [ID_W-1:0]   alloc_id;
   logic              full;
   logic              empty;
   logic [ID_W:0]     count;
   logic              retire_valid;
   logic [DEST_W-1:0] retire_dest;
   logic [PC_W-1:0]   retire_pc;
   logic              retire_flush;

   logic check_idle;
   logic check_full;

   // Reference model state, in allocation order
   logic [PC_W-1:0]   ref_pc_q[$];
   logic [DEST_W-1:0] ref_dest_q[$];
   logic [ID_W-1:0]   ref_id_q[$];
   logic [DEPTH-1:0]  wb_done;
   logic [DEPTH-1:0]  wb_mis;
   logic [ID_W-1:0]   exp_next_id;
   logic [ID_W-1:0]   popped_id;
   logic [ID_W-1:0]   exp_id;
   logic [PC_W-1:0]   exp_pc;
   logic [DEST_W-1:0] exp_dest;
   logic              exp_written;
   logic              exp_mis;
   int                exp_count;

   logic [ID_W-1:0] wb_order[$];
   logic [15:0]     lfsr_state = 16'd23879;
   int              errors = 0;
   int              test_start_errors;
   int              pass_count = 0;
   int              fail_count = 0;
   int              cycle_count = 0;

   rob_top #(
      .ROB_DEPTH (DEPTH),
      .PC_W      (PC_W)
   ) u_dut (
      .clk          (clk),
      .reset        (reset),
      .alloc        (alloc),
      .alloc_dest   (alloc_dest),
      .alloc_pc     (alloc_pc),
      .alloc_id     (alloc_id),
      .wb_valid     (wb_valid),
      .wb_id        (wb_id),
      .wb_mispred   (wb_mispred),
      .full         (full),
      .empty        (empty),
      .count        (count),
      .retire_valid (retire_valid),
      .retire_dest  (retire_dest),
      .retire_pc    (retire_pc),
      .retire_flush (retire_flush)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: run stopped after %0d cycles", cycle_count);
         $display("Some tests failed");
         $finish;
      end
   end

   // Tracks what the buffer should hold, from the inputs and the retire strobe
   always @(posedge clk) begin
      if (reset) begin
         ref_pc_q.delete();
         ref_dest_q.delete();
         ref_id_q.delete();
         wb_done = '0;
         wb_mis = '0;
         exp_next_id = '0;
      end else begin
         if (retire_valid && ref_id_q.size() != 0) begin
            popped_id = ref_id_q.pop_front();
            void'(ref_pc_q.pop_front());
            void'(ref_dest_q.pop_front());
         end
         if (retire_flush) begin
            ref_pc_q.delete();
            ref_dest_q.delete();
            ref_id_q.delete();
            exp_next_id = popped_id + ID_W'(1);
         end else begin
            if (wb_valid) begin
               wb_done[wb_id] = 1'b1;
               wb_mis[wb_id] = wb_mispred;
            end
            // Occupancy before this edge decides whether the alloc is taken
            if (alloc && exp_count < DEPTH) begin
               ref_pc_q.push_back(alloc_pc);
               ref_dest_q.push_back(alloc_dest);
               ref_id_q.push_back(exp_next_id);
               wb_done[exp_next_id] = 1'b0;
               wb_mis[exp_next_id] = 1'b0;
               exp_next_id = exp_next_id + ID_W'(1);
            end
         end
      end
      exp_count = ref_id_q.size();
      if (exp_count != 0) begin
         exp_id = ref_id_q[0];
         exp_pc = ref_pc_q[0];
         exp_dest = ref_dest_q[0];
         exp_written = wb_done[exp_id];
         exp_mis = wb_mis[exp_id];
      end else begin
         exp_written = 1'b0;
         exp_mis = 1'b0;
      end
   end

   task automatic report_value(string name, logic [31:0] exp, logic [31:0] act);
      $display("CHECK FAILED %s expected %h got %h", name, exp, act);
      errors++;
   endtask

   task automatic report_error(string msg);
      $display("%s", msg);
      errors++;
   endtask

   a_retire_known: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> exp_count != 0)
      else report_error("Retirement seen with no instruction outstanding");

   a_retire_written: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> exp_written)
      else report_error("Oldest entry retired before it was written back");

   a_retire_pc: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> retire_pc == exp_pc)
      else report_value("retire_pc", $sampled(exp_pc), $sampled(retire_pc));

   a_retire_dest: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> retire_dest == exp_dest)
      else report_value("retire_dest", 32'($sampled(exp_dest)), 32'($sampled(retire_dest)));

   a_retire_flush: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> retire_flush == exp_mis)
      else report_value("retire_flush", 32'($sampled(exp_mis)), 32'($sampled(retire_flush)));

   a_flush_empties: assert property (@(posedge clk) disable iff (reset)
      retire_flush |=> empty && count == '0)
      else report_error("Buffer not empty in the cycle after a flush");

   a_wb_latency: assert property (@(posedge clk) disable iff (reset)
      wb_valid && exp_count != 0 && wb_id == exp_id && !retire_flush |=> retire_valid)
      else report_error("No retirement in the cycle after a writeback to the head");

   a_alloc_id: assert property (@(posedge clk) disable iff (reset)
      alloc && exp_count < DEPTH && !retire_flush |-> alloc_id == exp_next_id)
      else report_value("alloc_id", 32'($sampled(exp_next_id)), 32'($sampled(alloc_id)));

   a_count: assert property (@(posedge clk) disable iff (reset)
      count == (ID_W+1)'(exp_count))
      else report_value("count", 32'($sampled(exp_count)), 32'($sampled(count)));

   a_idle_empty: assert property (@(posedge clk) disable iff (reset)
      check_idle |-> empty)
      else report_value("empty", 32'h1, 32'($sampled(empty)));

   a_idle_full: assert property (@(posedge clk) disable iff (reset)
      check_idle |-> !full)
      else report_value("full", 32'h0, 32'($sampled(full)));

   a_idle_retire: assert property (@(posedge clk) disable iff (reset)
      check_idle |-> !retire_valid && !retire_flush)
      else report_error("Retire strobe high while the buffer should be idle");

   a_full_flag: assert property (@(posedge clk) disable iff (reset)
      check_full |-> full)
      else report_value("full", 32'h1, 32'($sampled(full)));

   a_full_no_retire: assert property (@(posedge clk) disable iff (reset)
      check_full |-> !retire_valid)
      else report_value("retire_valid", 32'h0, 32'($sampled(retire_valid)));

   // 16-bit Galois LFSR, one step per bit
   function automatic logic [15:0] galois_step(logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 16'hB400;
      return n;
   endfunction

   task automatic rand_bits(int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = galois_step(lfsr_state);
      end
   endtask

   task automatic alloc_burst(int n);
      logic [31:0] pc;
      logic [31:0] d;
      for (int i = 0; i < n; i++) begin
         rand_bits(32, pc);
         rand_bits(DEST_W, d);
         @(posedge clk);
         alloc <= 1'b1;
         alloc_pc <= pc;
         alloc_dest <= d[DEST_W-1:0];
      end
      @(posedge clk);
      alloc <= 1'b0;
   endtask

   // Copy of the outstanding ids, taken once the model has settled
   task automatic take_ids();
      @(negedge clk);
      wb_order = ref_id_q;
   endtask

   task automatic shuffle_ids();
      logic [31:0] r;
      logic [ID_W-1:0] tmp;
      int j;
      for (int i = wb_order.size() - 1; i > 0; i--) begin
         rand_bits(ID_W, r);
         j = r % (i + 1);
         tmp = wb_order[i];
         wb_order[i] = wb_order[j];
         wb_order[j] = tmp;
      end
   endtask

   task automatic wb_one(logic [ID_W-1:0] id, logic mis);
      @(posedge clk);
      wb_valid <= 1'b1;
      wb_id <= id;
      wb_mispred <= mis;
      @(posedge clk);
      wb_valid <= 1'b0;
      wb_mispred <= 1'b0;
   endtask

   task automatic wait_empty();
      @(negedge clk);
      while (!empty) @(negedge clk);
   endtask

   task automatic pulse_idle_check();
      @(posedge clk);
      check_idle <= 1'b1;
      @(posedge clk);
      check_idle <= 1'b0;
   endtask

   task automatic finish_test(string name);
      repeat (2) @(posedge clk);
      if (errors == test_start_errors) begin
         pass_count++;
         $display("PASS %s", name);
      end else begin
         fail_count++;
         $display("FAIL %s (%0d errors)", name, errors - test_start_errors);
      end
      test_start_errors = errors;
   endtask

   initial begin
      reset = 1'b1;
      alloc = 1'b0;
      alloc_dest = '0;
      alloc_pc = '0;
      wb_valid = 1'b0;
      wb_id = '0;
      wb_mispred = 1'b0;
      check_idle = 1'b0;
      check_full = 1'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      test_start_errors = errors;

      pulse_idle_check();
      finish_test("reset_state");

      alloc_burst(6);
      take_ids();
      shuffle_ids();
      foreach (wb_order[i]) wb_one(wb_order[i], 1'b0);
      wait_empty();
      pulse_idle_check();
      finish_test("in_order_retire");

      alloc_burst(8);
      @(posedge clk);
      check_full <= 1'b1;
      @(posedge clk);
      check_full <= 1'b0;
      take_ids();
      shuffle_ids();
      foreach (wb_order[i]) wb_one(wb_order[i], 1'b0);
      wait_empty();
      pulse_idle_check();
      finish_test("fill_to_full");

      alloc_burst(2);
      take_ids();
      wb_one(wb_order[0], 1'b0);
      wb_one(wb_order[1], 1'b0);
      wait_empty();
      finish_test("retire_latency");

      alloc_burst(5);
      take_ids();
      wb_one(wb_order[2], 1'b1);
      wb_one(wb_order[0], 1'b0);
      wb_one(wb_order[1], 1'b0);
      wait_empty();
      pulse_idle_check();
      // First allocation after the flush lands at the new head
      alloc_burst(1);
      take_ids();
      wb_one(wb_order[0], 1'b0);
      wait_empty();
      finish_test("mispredict_flush");

      $display("Tests: %0d passed, %0d failed, %0d check errors",
               pass_count, fail_count, errors);
      if (fail_count == 0 && errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- rob_top.sv
`timescale 1ns/1ns

module rob_top #(
   parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
   parameter  int PC_W      = rob_pkg::PC_W_DEFAULT,
   localparam int ID_W      = $clog2(ROB_DEPTH)
) (
   input  logic                       clk,
   input  logic                       reset,

   input  logic                       alloc,
   input  logic [rob_pkg::DEST_W-1:0] alloc_dest,
   input  logic [PC_W-1:0]            alloc_pc,
   output logic [ID_W-1:0]            alloc_id,

   input  logic                       wb_valid,
   input  logic [ID_W-1:0]            wb_id,
   input  logic                       wb_mispred,

   output logic                       full,
   output logic                       empty,
   output logic [ID_W:0]              count,

   output logic                       retire_valid,
   output logic [rob_pkg::DEST_W-1:0] retire_dest,
   output logic [PC_W-1:0]            retire_pc,
   output logic                       retire_flush
);

   import rob_pkg::*;

   logic [ID_W-1:0] head;

   logic [ROB_DEPTH-1:0]             entry_valid;
   logic [ROB_DEPTH-1:0]             entry_ready;
   logic [ROB_DEPTH-1:0]             entry_flush_needed;
   logic [ROB_DEPTH-1:0][DEST_W-1:0] entry_dest;
   logic [ROB_DEPTH-1:0][PC_W-1:0]   entry_pc;

   // Tail is the id handed out to the next allocation
   rob_ptr_counter #(
      .ROB_DEPTH (ROB_DEPTH)
   ) u_ptr_counter (
      .clk       (clk),
      .reset     (reset),
      .alloc     (alloc),
      .retire    (retire_valid),
      .flush_now (retire_flush),
      .head      (head),
      .tail      (alloc_id),
      .count     (count),
      .full      (full),
      .empty     (empty)
   );

   for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_entry
      rob_entry #(
         .ROB_DEPTH (ROB_DEPTH),
         .PC_W      (PC_W),
         .ENTRY_ID  (i)
      ) u_entry (
         .clk          (clk),
         .reset        (reset),
         .alloc        (alloc),
         .alloc_id     (alloc_id),
         .alloc_dest   (alloc_dest),
         .alloc_pc     (alloc_pc),
         .wb_valid     (wb_valid),
         .wb_id        (wb_id),
         .wb_mispred   (wb_mispred),
         .retire       (retire_valid),
         .head         (head),
         .flush_now    (retire_flush),
         .valid        (entry_valid[i]),
         .ready        (entry_ready[i]),
         .flush_needed (entry_flush_needed[i]),
         .dest         (entry_dest[i]),
         .pc           (entry_pc[i])
      );
   end

   rob_retire_ctrl #(
      .ROB_DEPTH (ROB_DEPTH),
      .PC_W      (PC_W)
   ) u_retire_ctrl (
      .head               (head),
      .entry_ready        (entry_ready),
      .entry_flush_needed (entry_flush_needed),
      .entry_dest         (entry_dest),
      .entry_pc           (entry_pc),
      .retire             (retire_valid),
      .flush_now          (retire_flush),
      .retire_dest        (retire_dest),
      .retire_pc          (retire_pc)
   );

   // Occupancy count must agree with the entry state machines
   a_empty_all_idle: assert property (@(posedge clk) disable iff (reset)
      empty |-> entry_valid == '0);

   a_full_all_busy: assert property (@(posedge clk) disable iff (reset)
      full |-> &entry_valid);

endmodule

//--- rob_retire_ctrl.sv
`timescale 1ns/1ns

module rob_retire_ctrl #(
   parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
   parameter  int PC_W      = rob_pkg::PC_W_DEFAULT,
   localparam int ID_W      = $clog2(ROB_DEPTH)
) (
   input  logic [ID_W-1:0]                           head,
   input  logic [ROB_DEPTH-1:0]                      entry_ready,
   input  logic [ROB_DEPTH-1:0]                      entry_flush_needed,
   input  logic [ROB_DEPTH-1:0][rob_pkg::DEST_W-1:0] entry_dest,
   input  logic [ROB_DEPTH-1:0][PC_W-1:0]            entry_pc,
   output logic                                      retire,
   output logic                                      flush_now,
   output logic [rob_pkg::DEST_W-1:0]                retire_dest,
   output logic [PC_W-1:0]                           retire_pc
);

   // Head retires as soon as it is written back
   assign retire = entry_ready[head];

   // Mispredicted head takes the whole buffer down with it
   assign flush_now = retire && entry_flush_needed[head];

   // Payload only meaningful while retire is high
   assign retire_dest = entry_dest[head];
   assign retire_pc   = entry_pc[head];

endmodule

//--- rob_ptr_counter.sv
`timescale 1ns/1ns

module rob_ptr_counter #(
   parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
   localparam int ID_W      = $clog2(ROB_DEPTH)
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            alloc,
   input  logic            retire,
   input  logic            flush_now,
   output logic [ID_W-1:0] head,
   output logic [ID_W-1:0] tail,
   output logic [ID_W:0]   count,
   output logic            full,
   output logic            empty
);

   logic alloc_ok;

   assign alloc_ok = alloc && !full;

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else if (flush_now) begin
         // Flushing entry retires, everything behind it is dropped
         head  <= head + ID_W'(1);
         tail  <= head + ID_W'(1);
         count <= '0;
      end else begin
         if (alloc_ok) begin
            tail <= tail + ID_W'(1);
         end
         if (retire) begin
            head <= head + ID_W'(1);
         end
         unique case ({alloc_ok, retire})
            2'b10:   count <= count + (ID_W+1)'(1);
            2'b01:   count <= count - (ID_W+1)'(1);
            default: count <= count;
         endcase
      end
   end

   assign full  = (count == (ID_W+1)'(ROB_DEPTH));
   assign empty = (count == '0);

   a_count_range: assert property (@(posedge clk) disable iff (reset)
      count <= (ID_W+1)'(ROB_DEPTH));

   a_no_retire_empty: assert property (@(posedge clk) disable iff (reset)
      retire |-> !empty);

   a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
      alloc && !flush_now |-> !full);

endmodule

//--- rob_entry.sv
`timescale 1ns/1ns

module rob_entry #(
   parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
   parameter  int PC_W      = rob_pkg::PC_W_DEFAULT,
   parameter  int ENTRY_ID  = 0,
   localparam int ID_W      = $clog2(ROB_DEPTH)
) (
   input  logic                      clk,
   input  logic                      reset,

   input  logic                      alloc,
   input  logic [ID_W-1:0]           alloc_id,
   input  logic [rob_pkg::DEST_W-1:0] alloc_dest,
   input  logic [PC_W-1:0]           alloc_pc,

   input  logic                      wb_valid,
   input  logic [ID_W-1:0]           wb_id,
   input  logic                      wb_mispred,

   input  logic                      retire,
   input  logic [ID_W-1:0]           head,
   input  logic                      flush_now,

   output logic                      valid,
   output logic                      ready,
   output logic                      flush_needed,
   output logic [rob_pkg::DEST_W-1:0] dest,
   output logic [PC_W-1:0]           pc
);

   import rob_pkg::*;

   t_rob_state state, state_nxt;

   logic alloc_match;
   logic alloc_hit;
   logic wb_match;
   logic wb_hit;
   logic retire_hit;

   assign alloc_match = alloc && (alloc_id == ID_W'(ENTRY_ID));
   assign wb_match    = wb_valid && (wb_id == ID_W'(ENTRY_ID));
   assign retire_hit  = retire && (head == ID_W'(ENTRY_ID));

   // A flush cycle drops any alloc or writeback
   assign alloc_hit = alloc_match && !flush_now && (state == ROB_IDLE);
   assign wb_hit    = wb_match && !flush_now && (state == ROB_PENDING);

   always_comb begin
      state_nxt = state;
      unique case (state)
         ROB_IDLE: begin
            if (alloc_hit) state_nxt = ROB_PENDING;
         end
         ROB_PENDING: begin
            if (flush_now) state_nxt = ROB_IDLE;
            else if (wb_hit) state_nxt = ROB_READY;
         end
         ROB_READY: begin
            if (flush_now || retire_hit) state_nxt = ROB_IDLE;
         end
         default: state_nxt = ROB_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ROB_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Mispredict flag, cleared by each new allocation
   always_ff @(posedge clk) begin
      if (reset) begin
         flush_needed <= 1'b0;
      end else if (alloc_hit) begin
         flush_needed <= 1'b0;
      end else if (wb_hit && wb_mispred) begin
         flush_needed <= 1'b1;
      end
   end

   // Static payload
   always_ff @(posedge clk) begin
      if (alloc_hit) begin
         dest <= alloc_dest;
         pc   <= alloc_pc;
      end
   end

   assign valid = (state != ROB_IDLE);
   assign ready = (state == ROB_READY);

   a_wb_to_pending: assert property (@(posedge clk) disable iff (reset)
      wb_match && !flush_now |-> state == ROB_PENDING);

   a_alloc_to_idle: assert property (@(posedge clk) disable iff (reset)
      alloc_match && !flush_now |-> state == ROB_IDLE);

endmodule

//--- rob_pkg.sv
package rob_pkg;

   // Lifecycle of one reorder buffer entry
   typedef enum logic [1:0] {
      ROB_IDLE    = 2'd0,
      ROB_PENDING = 2'd1,
      ROB_READY   = 2'd2
   } t_rob_state;

   // Number of entries, must be a power of two
   localparam int ROB_DEPTH_DEFAULT = 8;

   localparam int PC_W_DEFAULT = 32;

   // Architectural register number width
   localparam int DEST_W = 5;

endpackage
